/* mixer_seq.f */
rtl/mix_pkg.sv
rtl/mac_if.sv
rtl/mix_fetch.sv
rtl/mac_queue.sv
rtl/mix_accum.sv
rtl/mixer_top.sv
verification/mixer_tb.sv

/* rtl/mac_if.sv */
`timescale 1ns/100ps

interface mac_if #(
    parameter int chan_w = 3
);

    import mix_pkg::*;

    logic                     push;
    entry_kind_t              kind;
    logic signed [prod_w-1:0] product;
    logic [chan_w-1:0]        chan;
    logic [2:0]               shift;

    logic                     pop;
    logic                     empty;
    logic [7:0]               level;   // Room for depth up to 255

    entry_kind_t              head_kind;
    logic signed [prod_w-1:0] head_product;
    logic [chan_w-1:0]        head_chan;
    logic [2:0]               head_shift;

    modport producer (
        output push, kind, product, chan, shift,
        input  level
    );

    modport queue (
        input  push, kind, product, chan, shift, pop,
        output empty, level, head_kind, head_product, head_chan, head_shift
    );

    modport consumer (
        output pop,
        input  empty, head_kind, head_product, head_chan, head_shift
    );

endinterface

/* rtl/mac_queue.sv */
`timescale 1ns/100ps

module mac_queue #(
    parameter int chan_w = 3,
    parameter int depth  = 8
) (
    input logic  ck,
    input logic  reset,
    mac_if.queue mq
);

    import mix_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    entry_kind_t              kind_mem  [depth];
    logic signed [prod_w-1:0] prod_mem  [depth];
    logic [chan_w-1:0]        chan_mem  [depth];
    logic [2:0]               shift_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // Wraps at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge ck) begin
        if (mq.push) begin
            kind_mem[wr_ptr]  <= mq.kind;
            prod_mem[wr_ptr]  <= mq.product;
            chan_mem[wr_ptr]  <= mq.chan;
            shift_mem[wr_ptr] <= mq.shift;
        end
    end

    always_ff @(posedge ck) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (mq.push)
                wr_ptr <= next_ptr(wr_ptr);
            if (mq.pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({mq.push, mq.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign mq.empty        = (count == '0);
    assign mq.level        = 8'(count);
    assign mq.head_kind    = kind_mem[rd_ptr];
    assign mq.head_product = prod_mem[rd_ptr];
    assign mq.head_chan    = chan_mem[rd_ptr];
    assign mq.head_shift   = shift_mem[rd_ptr];

endmodule

/* rtl/mix_accum.sv */
`timescale 1ns/100ps

module mix_accum #(
    parameter int chan_w = 3,
    parameter int acc_w  = 40
) (
    input  logic                        ck,
    input  logic                        reset,
    input  logic                        out_ready,
    mac_if.consumer                     mq,
    output logic                        out_we,
    output logic [chan_w-1:0]           out_addr,
    output logic [mix_pkg::gain_w-1:0]  out_audio,
    output logic                        done,
    output logic                        error
);

    import mix_pkg::*;

    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] addend;
    logic                    stall;

    // 16-bit window at 4*s, shift 7 reads as zero
    function automatic logic [gain_w-1:0] acc_slice(
        input logic [acc_w-1:0] a,
        input logic [2:0]       s
    );
        logic [acc_w-1:0] shifted;
        shifted = a >> (4 * s);
        return (s == 3'd7) ? '0 : shifted[gain_w-1:0];
    endfunction

    assign addend = {{(acc_w - prod_w){mq.head_product[prod_w-1]}}, mq.head_product};

    // Pending write blocks the queue
    assign stall  = out_we && !out_ready;
    assign mq.pop = !mq.empty && !stall && !done;

    always_ff @(posedge ck) begin
        if (!reset) begin
            acc    <= '0;
            out_we <= 1'b0;
            done   <= 1'b0;
            error  <= 1'b0;
        end else begin
            if (out_we && out_ready)
                out_we <= 1'b0;
            if (mq.pop) begin
                case (mq.head_kind)
                    mac:     acc <= acc + addend;
                    mac_clr: acc <= addend;
                    write:   out_we <= 1'b1;   // Overrides the clear above
                    halt: begin
                        done <= 1'b1;
                        if (mq.head_chan[0])
                            error <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Held steady while out_ready is low since pop is blocked
    always_ff @(posedge ck) begin
        if (mq.pop && mq.head_kind == write) begin
            out_addr  <= mq.head_chan;
            out_audio <= acc_slice(acc, mq.head_shift);
        end
    end

endmodule

/* rtl/mix_fetch.sv */
`timescale 1ns/100ps

module mix_fetch #(
    parameter int frame_w = 4,
    parameter int chan_w  = 3,
    parameter int code_w  = 8,
    parameter int depth   = 8
) (
    input  logic                        ck,
    input  logic                        reset,
    input  logic [frame_w-1:0]          frame,
    output logic [code_w-1:0]           coef_addr,
    input  logic [31:0]                 coef_data,
    output logic [chan_w+frame_w-1:0]   audio_raddr,
    input  logic [mix_pkg::gain_w-1:0]  audio_in,
    mac_if.producer                     mq
);

    import mix_pkg::*;

    logic [6:0]         opcode;
    logic [gain_w-1:0]  word_gain;
    logic [chan_w-1:0]  word_chan;
    logic [frame_w-1:0] word_offset;

    logic stop;      // Halt or bad opcode seen
    logic stall;
    logic issue;
    logic fetch_v;   // coef_data belongs to a live fetch

    // Decoded instruction
    logic               ir_v;
    entry_kind_t        ir_kind;
    logic [gain_w-1:0]  ir_gain;
    logic [chan_w-1:0]  ir_chan;
    logic [frame_w-1:0] ir_offset;

    // Sample address on the bus
    logic               a_v;
    entry_kind_t        a_kind;
    logic [gain_w-1:0]  a_gain;
    logic [chan_w-1:0]  a_chan;
    logic [2:0]         a_shift;

    // Sample arriving
    logic                     b_v;
    entry_kind_t              b_kind;
    logic signed [gain_w-1:0] b_gain;
    logic [chan_w-1:0]        b_chan;
    logic [2:0]               b_shift;

    assign opcode      = coef_data[31:op_lsb];
    assign word_gain   = coef_data[gain_w-1:0];
    assign word_chan   = coef_data[gain_w +: chan_w];
    assign word_offset = coef_data[gain_w+chan_w +: frame_w];

    // Leaves room for the words already in the pipe
    assign stall = mq.level >= 8'(depth - 4);
    assign issue = !stop && !stall;

    always_ff @(posedge ck) begin
        if (!reset) begin
            coef_addr <= '0;
            fetch_v   <= 1'b0;
        end else begin
            fetch_v <= issue;
            if (issue)
                coef_addr <= coef_addr + 1'b1;
        end
    end

    always_ff @(posedge ck) begin
        if (!reset) begin
            stop <= 1'b0;
            ir_v <= 1'b0;
        end else begin
            ir_v <= 1'b0;
            if (fetch_v && !stop) begin
                case (opcode)
                    op_mac, op_mac_clr, op_write: ir_v <= 1'b1;
                    op_noop: ;                         // Never queued
                    default: begin
                        ir_v <= 1'b1;
                        stop <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge ck) begin
        ir_gain   <= word_gain;
        ir_offset <= word_offset;
        ir_chan   <= word_chan;
        case (opcode)
            op_mac:     ir_kind <= mac;
            op_mac_clr: ir_kind <= mac_clr;
            op_write:   ir_kind <= write;
            default: begin
                ir_kind <= halt;
                ir_chan <= chan_w'(opcode != op_halt);   // Error flag
            end
        endcase
    end

    always_ff @(posedge ck) begin
        if (!reset) begin
            a_v     <= 1'b0;
            b_v     <= 1'b0;
            mq.push <= 1'b0;
        end else begin
            a_v     <= ir_v;
            b_v     <= a_v;
            mq.push <= b_v;
        end
    end

    always_ff @(posedge ck) begin
        // Address only moves for a live instruction
        if (ir_v) begin
            audio_raddr <= {ir_chan, frame + ir_offset};
            a_kind      <= ir_kind;
            a_gain      <= ir_gain;
            a_chan      <= ir_chan;
            a_shift     <= ir_offset[2:0];
        end
        b_kind  <= a_kind;
        b_gain  <= a_gain;
        b_chan  <= a_chan;
        b_shift <= a_shift;

        mq.product <= b_gain * $signed(audio_in);
        mq.kind    <= b_kind;
        mq.chan    <= b_chan;
        mq.shift   <= b_shift;
    end

endmodule

/* rtl/mix_pkg.sv */
package mix_pkg;

    // Opcodes in bits 31:25 of the instruction word
    localparam logic [6:0] op_halt    = 7'h00;
    localparam logic [6:0] op_mac     = 7'h40;
    localparam logic [6:0] op_mac_clr = 7'h41;
    localparam logic [6:0] op_write   = 7'h42;
    localparam logic [6:0] op_noop    = 7'h7F;

    localparam int gain_w = 16;   // Gain and sample width
    localparam int prod_w = 32;
    localparam int op_lsb = 25;

    // Queue entry kinds
    typedef enum logic [1:0] {
        mac     = 2'd0,
        mac_clr = 2'd1,
        write   = 2'd2,
        halt    = 2'd3    // Error flag rides in chan bit 0
    } entry_kind_t;

endpackage

/* rtl/mixer_top.sv */
`timescale 1ns/100ps

module mixer_top #(
    parameter int frame_w = 4,
    parameter int chan_w  = 3,
    parameter int code_w  = 8,
    parameter int acc_w   = 40,
    parameter int depth   = 8
) (
    input  logic                        ck,
    input  logic                        reset,
    input  logic [frame_w-1:0]          frame,
    output logic [code_w-1:0]           coef_addr,
    input  logic [31:0]                 coef_data,
    output logic [chan_w+frame_w-1:0]   audio_raddr,
    input  logic [mix_pkg::gain_w-1:0]  audio_in,
    input  logic                        out_ready,
    output logic                        out_we,
    output logic [chan_w-1:0]           out_addr,
    output logic [mix_pkg::gain_w-1:0]  out_audio,
    output logic                        done,
    output logic                        error
);

    mac_if #(.chan_w(chan_w)) mq ();

    mix_fetch #(
        .frame_w (frame_w),
        .chan_w  (chan_w),
        .code_w  (code_w),
        .depth   (depth)
    ) fetch0 (
        .ck          (ck),
        .reset       (reset),
        .frame       (frame),
        .coef_addr   (coef_addr),
        .coef_data   (coef_data),
        .audio_raddr (audio_raddr),
        .audio_in    (audio_in),
        .mq          (mq.producer)
    );

    mac_queue #(.chan_w(chan_w), .depth(depth)) queue0 (
        .ck    (ck),
        .reset (reset),
        .mq    (mq.queue)
    );

    mix_accum #(.chan_w(chan_w), .acc_w(acc_w)) accum0 (
        .ck        (ck),
        .reset     (reset),
        .out_ready (out_ready),
        .mq        (mq.consumer),
        .out_we    (out_we),
        .out_addr  (out_addr),
        .out_audio (out_audio),
        .done      (done),
        .error     (error)
    );

endmodule

/* verification/mixer_tb.sv */
`timescale 1ns/100ps

module mixer_tb;

    localparam int frame_w    = 4;
    localparam int chan_w     = 3;
    localparam int code_w     = 8;
    localparam int addr_w     = chan_w + frame_w;
    localparam int max_wr     = 16;
    localparam int done_limit = 2000;

    logic               ck;
    logic               reset;
    logic [frame_w-1:0] frame;
    logic [code_w-1:0]  coef_addr;
    logic [31:0]        coef_data;
    logic [addr_w-1:0]  audio_raddr;
    logic [15:0]        audio_in;
    logic               out_ready;
    logic               out_we;
    logic [chan_w-1:0]  out_addr;
    logic [15:0]        out_audio;
    logic               done;
    logic               error;

    logic [31:0]       coef_mem   [2**code_w];
    logic [15:0]       sample_mem [2**addr_w];
    logic [chan_w-1:0] exp_addr   [max_wr];
    logic [15:0]       exp_audio  [max_wr];
    int                exp_count;
    int                seen_count;
    logic              exp_error;
    logic              rand_ready;   // Random out_ready lows in this section
    int                fd;
    int                seed_draw;
    logic [8*256-1:0]  line;

    mixer_top #(
        .frame_w (frame_w),
        .chan_w  (chan_w),
        .code_w  (code_w),
        .acc_w   (40),
        .depth   (8)
    ) dut0 (
        .ck          (ck),
        .reset       (reset),
        .frame       (frame),
        .coef_addr   (coef_addr),
        .coef_data   (coef_data),
        .audio_raddr (audio_raddr),
        .audio_in    (audio_in),
        .out_ready   (out_ready),
        .out_we      (out_we),
        .out_addr    (out_addr),
        .out_audio   (out_audio),
        .done        (done),
        .error       (error)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] got);
        stop_run($sformatf("mismatch at %0d ns: %s expected %h, got %h", $time, name, expv, got));
    endtask

    task automatic read_dec(output int v);
        int r;
        r = $fscanf(fd, "%d", v);
        assert (r == 1) else stop_run("vectors file ended early or holds a bad count");
    endtask

    task automatic read_hex(output logic [31:0] v);
        int r;
        r = $fscanf(fd, "%h", v);
        assert (r == 1) else stop_run("vectors file ended early or holds a bad hex word");
    endtask

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    // Memories answer one cycle after the address
    always @(posedge ck) begin
        coef_data <= coef_mem[coef_addr];
        audio_in  <= sample_mem[audio_raddr];
    end

    // Ready low on about 30 percent of cycles when enabled
    initial begin
        seed_draw = $urandom(96567);
        forever begin
            @(posedge ck);
            out_ready <= !rand_ready || (($urandom % 100) < 70);
        end
    end

    // Accepted writes, checked in order
    always @(posedge ck) begin
        if (reset && out_we && out_ready) begin
            assert (!done) else stop_run("a write was accepted after done");
            assert (seen_count < exp_count) else stop_run("more writes than expected");
            assert (out_addr == exp_addr[seen_count]) else
                report_mismatch("out_addr", exp_addr[seen_count], out_addr);
            assert (out_audio == exp_audio[seen_count]) else
                report_mismatch("out_audio", exp_audio[seen_count], out_audio);
            seen_count++;
        end
    end

    task automatic run_section(input int index);
        int          n;
        int          i;
        int          a;
        int          waited;
        logic [31:0] w;
        logic [31:0] v;
        @(posedge ck);
        reset <= 1'b0;
        for (a = 0; a < 2**code_w; a++)
            coef_mem[a] = {7'h7F, 25'(a)};            // No-op with its address
        for (a = 0; a < 2**addr_w; a++)
            sample_mem[a] = 16'(a * 16'h0123 + 16'h0400);
        read_dec(n);
        frame <= frame_w'(n);
        read_dec(n);
        rand_ready = (n != 0);
        read_dec(n);
        for (i = 0; i < n; i++) begin
            read_hex(w);
            coef_mem[i] = w;
        end
        read_dec(n);
        for (i = 0; i < n; i++) begin
            read_hex(w);
            read_hex(v);
            sample_mem[w[addr_w-1:0]] = v[15:0];
        end
        read_dec(exp_count);
        assert (exp_count <= max_wr) else stop_run("too many expected writes in vectors file");
        for (i = 0; i < exp_count; i++) begin
            read_hex(w);
            read_hex(v);
            exp_addr[i]  = w[chan_w-1:0];
            exp_audio[i] = v[15:0];
        end
        read_dec(n);
        exp_error  = (n != 0);
        seen_count = 0;
        repeat (8) @(posedge ck);
        reset <= 1'b1;

        waited = 0;
        while (!done && waited < done_limit) begin
            @(posedge ck);
            waited++;
        end
        assert (done) else stop_run($sformatf("section %0d timed out waiting for done", index));
        repeat (20) @(posedge ck);   // Catch any late write
        assert (seen_count == exp_count) else
            stop_run($sformatf("section %0d saw %0d writes but expected %0d",
                               index, seen_count, exp_count));
        assert (error == exp_error) else report_mismatch("error", exp_error, error);
    endtask

    initial begin
        reset      = 1'b0;
        frame      = '0;
        coef_data  = '0;
        audio_in   = '0;
        out_ready  = 1'b0;
        rand_ready = 1'b0;
        exp_count  = 0;
        seen_count = 0;
        exp_error  = 1'b0;
        fd = $fopen("verification/mixer_vectors.txt", "r");
        assert (fd != 0) else stop_run("cannot open verification/mixer_vectors.txt");
        assert ($fgets(line, fd) > 0) else stop_run("vectors file has no header");
        assert ($fgets(line, fd) > 0) else stop_run("vectors file has no header");
        run_section(1);
        run_section(2);   // Undefined opcode case
        $fclose(fd);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verification/mixer_vectors.txt */
// Per section: frame and random out_ready flag (dec), program count (dec) and words (hex),
// sample count (dec) and addr/value pairs (hex), write count (dec) and pairs (hex), error (dec)
5 1
13
82010100 8011FFFE FE000000 806A0003
84030000 82004000 80082000 FE000000
84250000 825EFFFF 84060000 840F0000
00000000
6
15 0040  17 0300  22 FF00
05 7000  06 1000  60 1234
4
3 3700  5 1E00
6 EDCC  7 FEDC
0
2 0
7
82040005 84020000 2A000000 84010000
82000001 84040000 00000000
1
42 0010
1
2 0050
1
